// File: Bender.yml
package:
  name: fp_add

sources:
  # synthesizable datapath
  - files:
      - logic/fp_add_pkg.sv
      - logic/fp_operand_align.sv
      - logic/fp_sum_normalize.sv
      - logic/fp_round_pack.sv
      - logic/fp_add_top.sv

  # simulation only
  - target: test
    files:
      - tests/fp_add_props.sv
      - tests/fp_add_tb.sv

// File: filelist.f
logic/fp_add_pkg.sv
logic/fp_operand_align.sv
logic/fp_sum_normalize.sv
logic/fp_round_pack.sv
logic/fp_add_top.sv
tests/fp_add_props.sv
tests/fp_add_tb.sv

// File: logic/fp_add_pkg.sv
package fp_add_pkg;

	// single precision word layout
	localparam int FP_WIDTH = 32;
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;
	localparam int MANT_W   = FRAC_W + 1;   // hidden bit on top
	localparam int GRS_W    = 3;            // guard, round, sticky
	localparam int EXT_W    = MANT_W + GRS_W;

	// all ones exponent marks infinity (255)
	localparam logic [EXP_W-1:0] EXP_MAX = '1;

	localparam int MODE_W = 3;

	// rounding mode codes
	localparam logic [MODE_W-1:0] RM_RNE = 3'd0;   // ties to even
	localparam logic [MODE_W-1:0] RM_RNA = 3'd1;   // ties away from zero
	localparam logic [MODE_W-1:0] RM_RTP = 3'd2;   // toward +inf
	localparam logic [MODE_W-1:0] RM_RTN = 3'd3;   // toward -inf
	localparam logic [MODE_W-1:0] RM_RTZ = 3'd4;   // chop

	// ieee 754 field view
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;    // biased
		logic [FRAC_W-1:0] frac;   // no hidden bit
	} fp_fields_t;

	// same 32 bits seen raw or split into fields
	typedef union packed {
		logic [FP_WIDTH-1:0] raw;
		fp_fields_t          fields;
	} fp_word_u;

endpackage

// File: logic/fp_add_top.sv
`timescale 1ns/1ps

module fp_add_top (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  logic                            i_valid,
	input  logic                            i_op,      // 1 subtracts b
	input  logic [fp_add_pkg::MODE_W-1:0]   i_mode,
	input  logic [fp_add_pkg::FP_WIDTH-1:0] i_a,
	input  logic [fp_add_pkg::FP_WIDTH-1:0] i_b,
	output logic                            o_valid,   // two cycles after i_valid
	output logic [fp_add_pkg::FP_WIDTH-1:0] o_result,
	output logic                            o_inexact
);
	import fp_add_pkg::*;

	// stage 1 registers out of the align block
	logic                    s1_valid;
	logic [MODE_W-1:0]       s1_mode;
	logic                    s1_sign;
	logic                    s1_eff_sub;
	logic [EXP_W-1:0]        s1_exp;
	logic [EXT_W-1:0]        s1_big;
	logic [EXT_W-1:0]        s1_small;
	logic                    s1_zero_sign;
	logic                    s1_spec;
	logic [FP_WIDTH-1:0]     s1_spec_word;

	// combinational sum, feeds the output register
	logic [EXT_W-1:0]        n_mant;
	logic signed [EXP_W+1:0] n_exp;
	logic                    n_zero;

	fp_operand_align u_align (
		.i_clk                 (i_clk),
		.i_rst                 (i_rst),
		.i_valid               (i_valid),
		.i_op                  (i_op),
		.i_mode                (i_mode),
		.i_a                   (i_a),
		.i_b                   (i_b),
		.o_valid               (s1_valid),
		.o_mode                (s1_mode),
		.o_sign                (s1_sign),
		.o_eff_sub             (s1_eff_sub),
		.o_exp                 (s1_exp),
		.o_big                 (s1_big),
		.o_small               (s1_small),
		.o_same_sign_zero_sign (s1_zero_sign),
		.o_spec                (s1_spec),
		.o_spec_word           (s1_spec_word)
	);

	fp_sum_normalize u_norm (
		.i_eff_sub (s1_eff_sub),
		.i_exp     (s1_exp),
		.i_big     (s1_big),
		.i_small   (s1_small),
		.o_mant    (n_mant),
		.o_exp     (n_exp),
		.o_zero    (n_zero)
	);

	fp_round_pack u_round (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_valid     (s1_valid),
		.i_mode      (s1_mode),
		.i_sign      (s1_sign),
		.i_zero_sign (s1_zero_sign),
		.i_mant      (n_mant),
		.i_exp       (n_exp),
		.i_zero      (n_zero),
		.i_spec      (s1_spec),
		.i_spec_word (s1_spec_word),
		.o_valid     (o_valid),
		.o_result    (o_result),
		.o_inexact   (o_inexact)
	);

endmodule

// File: logic/fp_operand_align.sv
`timescale 1ns/1ps

module fp_operand_align (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  logic                            i_valid,
	input  logic                            i_op,     // 0 add, 1 sub
	input  logic [fp_add_pkg::MODE_W-1:0]   i_mode,
	input  logic [fp_add_pkg::FP_WIDTH-1:0] i_a,
	input  logic [fp_add_pkg::FP_WIDTH-1:0] i_b,
	output logic                            o_valid,
	output logic [fp_add_pkg::MODE_W-1:0]   o_mode,
	output logic                            o_sign,   // sign of the larger magnitude
	output logic                            o_eff_sub,
	output logic [fp_add_pkg::EXP_W-1:0]    o_exp,
	output logic [fp_add_pkg::EXT_W-1:0]    o_big,
	output logic [fp_add_pkg::EXT_W-1:0]    o_small,
	output logic                            o_same_sign_zero_sign,
	output logic                            o_spec,
	output logic [fp_add_pkg::FP_WIDTH-1:0] o_spec_word
);
	import fp_add_pkg::*;

	fp_word_u          word_a;
	fp_word_u          word_b;
	logic              sign_a;
	logic              sign_b;       // after the op flip
	logic [EXP_W-1:0]  exp_a;
	logic [EXP_W-1:0]  exp_b;
	logic [MANT_W-1:0] mant_a;
	logic [MANT_W-1:0] mant_b;
	logic              inf_a;
	logic              inf_b;
	logic              a_wins;       // |a| >= |b|
	logic              big_sign;
	logic [EXP_W-1:0]  big_exp;
	logic [MANT_W-1:0] big_mant;
	logic [EXP_W-1:0]  small_exp;
	logic [MANT_W-1:0] small_mant;
	logic [EXP_W-1:0]  exp_diff;
	logic [EXT_W-1:0]  small_ext;
	logic [EXT_W-1:0]  shifted;
	logic [EXT_W-1:0]  lost_mask;
	logic              sticky;
	logic              eff_sub;
	logic              zero_sign;
	fp_word_u          spec_word;

	always_comb begin
		word_a.raw = i_a;
		word_b.raw = i_b;
	end

	assign sign_a = word_a.fields.sign;
	assign sign_b = word_b.fields.sign ^ i_op;   // a - b is a + (-b)
	assign exp_a  = word_a.fields.exp;
	assign exp_b  = word_b.fields.exp;

	// exp 0 means zero here, subnormal fraction dropped
	assign mant_a = (exp_a == '0) ? '0 : {1'b1, word_a.fields.frac};
	assign mant_b = (exp_b == '0) ? '0 : {1'b1, word_b.fields.frac};

	assign inf_a = (exp_a == EXP_MAX);
	assign inf_b = (exp_b == EXP_MAX);

	// exponent first then significand
	assign a_wins = ({exp_a, mant_a} >= {exp_b, mant_b});

	assign big_sign   = a_wins ? sign_a : sign_b;
	assign big_exp    = a_wins ? exp_a : exp_b;
	assign big_mant   = a_wins ? mant_a : mant_b;
	assign small_exp  = a_wins ? exp_b : exp_a;
	assign small_mant = a_wins ? mant_b : mant_a;

	assign eff_sub  = sign_a ^ sign_b;
	assign exp_diff = big_exp - small_exp;   // never negative

	// alignment shift, every bit pushed out lands in sticky
	assign small_ext = {small_mant, {GRS_W{1'b0}}};
	assign shifted   = small_ext >> exp_diff;
	assign lost_mask = ~({EXT_W{1'b1}} << exp_diff);   // all ones once diff passes 26
	assign sticky    = |(small_ext & lost_mask);

	// exact zero sign
	// like signs keep it, unlike signs give -0 only toward -inf
	assign zero_sign = eff_sub ? (i_mode == RM_RTN) : sign_a;

	// infinity result, a takes precedence
	always_comb begin
		spec_word.fields.sign = inf_a ? sign_a : sign_b;
		spec_word.fields.exp  = EXP_MAX;
		spec_word.fields.frac = '0;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// stage 1 payload, loads only with a new op
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_mode                <= i_mode;
			o_sign                <= big_sign;
			o_eff_sub             <= eff_sub;
			o_exp                 <= big_exp;
			o_big                 <= {big_mant, {GRS_W{1'b0}}};
			o_small               <= {shifted[EXT_W-1:1], shifted[0] | sticky};
			o_same_sign_zero_sign <= zero_sign;
			o_spec                <= inf_a | inf_b;
			o_spec_word           <= spec_word.raw;
		end
	end

endmodule

// File: logic/fp_round_pack.sv
`timescale 1ns/1ps

module fp_round_pack (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  logic                                i_valid,
	input  logic [fp_add_pkg::MODE_W-1:0]       i_mode,
	input  logic                                i_sign,
	input  logic                                i_zero_sign,   // sign for an exact zero
	input  logic [fp_add_pkg::EXT_W-1:0]        i_mant,
	input  logic signed [fp_add_pkg::EXP_W+1:0] i_exp,
	input  logic                                i_zero,
	input  logic                                i_spec,
	input  logic [fp_add_pkg::FP_WIDTH-1:0]     i_spec_word,
	output logic                                o_valid,
	output logic [fp_add_pkg::FP_WIDTH-1:0]     o_result,
	output logic                                o_inexact
);
	import fp_add_pkg::*;

	logic [MANT_W-1:0]       keep;        // hidden bit plus fraction
	logic                    guard;
	logic                    rnd;
	logic                    sticky;
	logic                    lost;        // anything below the lsb
	logic                    round_up;
	logic [MANT_W:0]         rounded;     // room for the rounding carry
	logic [FRAC_W-1:0]       frac_fin;
	logic signed [EXP_W+1:0] exp_fin;
	fp_word_u                res_word;
	logic                    res_inexact;

	assign keep   = i_mant[EXT_W-1:GRS_W];
	assign guard  = i_mant[2];
	assign rnd    = i_mant[1];
	assign sticky = i_mant[0];
	assign lost   = guard | rnd | sticky;

	always_comb begin
		case (i_mode)
			RM_RNA:  round_up = guard;               // ties go away from zero
			RM_RTP:  round_up = ~i_sign & lost;
			RM_RTN:  round_up = i_sign & lost;
			RM_RTZ:  round_up = 1'b0;
			default: round_up = guard & (rnd | sticky | keep[0]);   // RNE and unused codes
		endcase
	end

	assign rounded = {1'b0, keep} + (MANT_W + 1)'(round_up);

	// 1.111..1 + ulp gives 10.000..0
	// fraction goes to zero and exponent steps up
	assign frac_fin = rounded[MANT_W] ? rounded[FRAC_W:1] : rounded[FRAC_W-1:0];
	assign exp_fin  = i_exp + $signed({{(EXP_W + 1){1'b0}}, rounded[MANT_W]});

	// priority special, zero, overflow, underflow, normal
	always_comb begin
		res_word.raw = '0;
		res_inexact  = 1'b0;
		if (i_spec) begin
			res_word.raw = i_spec_word;   // infinity passes through exact
		end else if (i_zero) begin
			res_word.fields.sign = i_zero_sign;
		end else if (exp_fin >= $signed({2'b00, EXP_MAX})) begin
			res_word.fields.sign = i_sign;   // overflow to inf in every mode
			res_word.fields.exp  = EXP_MAX;
			res_inexact          = 1'b1;
		end else if (exp_fin < 10'sd1) begin
			res_word.fields.sign = i_sign;   // flush to signed zero
			res_inexact          = 1'b1;
		end else begin
			res_word.fields.sign = i_sign;
			res_word.fields.exp  = exp_fin[EXP_W-1:0];
			res_word.fields.frac = frac_fin;
			res_inexact          = lost;
		end
	end

	// output register holds its value between ops
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_valid   <= 1'b0;
			o_result  <= '0;
			o_inexact <= 1'b0;
		end else begin
			o_valid <= i_valid;
			if (i_valid) begin
				o_result  <= res_word.raw;
				o_inexact <= res_inexact;
			end
		end
	end

endmodule

// File: logic/fp_sum_normalize.sv
`timescale 1ns/1ps

module fp_sum_normalize (
	input  logic                                i_eff_sub,
	input  logic [fp_add_pkg::EXP_W-1:0]        i_exp,     // larger exponent
	input  logic [fp_add_pkg::EXT_W-1:0]        i_big,
	input  logic [fp_add_pkg::EXT_W-1:0]        i_small,   // already aligned
	output logic [fp_add_pkg::EXT_W-1:0]        o_mant,    // hidden bit at msb
	output logic signed [fp_add_pkg::EXP_W+1:0] o_exp,     // may leave 1..254
	output logic                                o_zero
);
	import fp_add_pkg::*;

	localparam int LZC_W = $clog2(EXT_W + 1);

	logic [EXT_W:0]          sum;        // extra carry bit
	logic [LZC_W-1:0]        lzc;
	logic [EXT_W-1:0]        shifted_l;
	logic signed [EXP_W+1:0] exp_ext;

	// big >= small, so a subtract never goes negative
	always_comb begin
		if (i_eff_sub) begin
			sum = {1'b0, i_big} - {1'b0, i_small};
		end else begin
			sum = {1'b0, i_big} + {1'b0, i_small};
		end
	end

	// leading zero count over the low 27 bits
	always_comb begin
		lzc = LZC_W'(EXT_W);   // all zero
		for (int i = 0; i < EXT_W; i++) begin
			if (sum[i]) begin
				lzc = LZC_W'(EXT_W - 1 - i);   // highest set bit wins
			end
		end
	end

	assign shifted_l = sum[EXT_W-1:0] << lzc;
	assign exp_ext   = $signed({2'b00, i_exp});
	assign o_zero    = (sum == '0);

	always_comb begin
		if (sum[EXT_W]) begin
			// carry out of an add
			// one step right, folding the dropped bit into sticky
			o_mant = {sum[EXT_W:2], sum[1] | sum[0]};
			o_exp  = exp_ext + 10'sd1;
		end else begin
			o_mant = shifted_l;   // cancellation, pull the leading one up
			o_exp  = exp_ext - $signed({{(EXP_W + 2 - LZC_W){1'b0}}, lzc});
		end
	end

endmodule

// File: tests/fp_add_input.txt
// columns: group mode op a b expected_result expected_inexact, all hex
// groups: 1 exact, 2 rounding, 3 cancellation, 4 over/underflow, 5 infinity, 6 streaming
1 0 0 3f800000 40000000 40400000 0
1 0 0 3f800000 3f800000 40000000 0
1 0 0 3fc00000 bf000000 3f800000 0
1 0 1 40400000 3f800000 40000000 0
1 0 0 c0200000 3f800000 bfc00000 0
1 0 1 3f800000 40800000 c0400000 0
1 0 0 3e800000 42c80000 42c88000 0
1 0 0 00000000 40a00000 40a00000 0
// 1.0 + half ulp, tie with even lsb
2 0 0 3f800000 33800000 3f800000 1
2 1 0 3f800000 33800000 3f800001 1
2 2 0 3f800000 33800000 3f800001 1
2 3 0 3f800000 33800000 3f800000 1
2 4 0 3f800000 33800000 3f800000 1
// tie with odd lsb
2 0 0 3f800001 33800000 3f800002 1
2 1 0 3f800001 33800000 3f800002 1
2 2 0 3f800001 33800000 3f800002 1
2 3 0 3f800001 33800000 3f800001 1
2 4 0 3f800001 33800000 3f800001 1
// negative, quarter ulp below
2 0 0 bf800000 b3000000 bf800000 1
2 1 0 bf800000 b3000000 bf800000 1
2 2 0 bf800000 b3000000 bf800000 1
2 3 0 bf800000 b3000000 bf800001 1
2 4 0 bf800000 b3000000 bf800000 1
3 0 1 40490fdb 40490fdb 00000000 0
3 1 1 40490fdb 40490fdb 00000000 0
3 2 1 40490fdb 40490fdb 00000000 0
3 3 1 40490fdb 40490fdb 80000000 0
3 4 1 40490fdb 40490fdb 00000000 0
3 0 0 80000000 80000000 80000000 0
4 0 0 7f7fffff 7f7fffff 7f800000 1
4 4 0 7f7fffff 7f7fffff 7f800000 1
4 0 1 80800001 80800000 80000000 1
5 0 0 7f800000 3f800000 7f800000 0
5 0 0 3f800000 ff800000 ff800000 0
5 0 1 3f800000 7f800000 ff800000 0
6 0 0 40400000 40800000 40e00000 0
6 0 1 41200000 40a00000 40a00000 0
6 1 0 3f800000 33800000 3f800001 1
6 3 0 bf800000 b3000000 bf800001 1
6 3 1 40490fdb 40490fdb 80000000 0
6 0 0 7f7fffff 7f7fffff 7f800000 1

// File: tests/fp_add_props.sv
`timescale 1ns/1ps

module fp_add_props (
	input logic                            i_clk,
	input logic                            i_rst,
	input logic                            i_in_valid,    // dut i_valid
	input logic                            i_out_valid,   // dut o_valid
	input logic [fp_add_pkg::FP_WIDTH-1:0] i_result,
	input logic                            i_inexact
);
	import fp_add_pkg::*;

	// sync reset clears the output strobe
	a_reset_valid: assert property (@(posedge i_clk) i_rst |=> !i_out_valid)
		else $error("o_valid high in the cycle after reset");

	a_latency: assert property (@(posedge i_clk) disable iff (i_rst)
		i_out_valid == $past(i_in_valid, 2))
		else $error("o_valid does not follow i_valid by two cycles");

	// output register only loads with a result
	a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		!i_out_valid |-> ($stable(i_result) && $stable(i_inexact)))
		else $error("result changed while o_valid low");

	a_no_nan: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_out_valid && i_result[FP_WIDTH-2 -: EXP_W] == EXP_MAX) |->
		(i_result[FRAC_W-1:0] == '0))
		else $error("all ones exponent with nonzero fraction");

endmodule

bind fp_add_top fp_add_props u_props (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_in_valid  (i_valid),
	.i_out_valid (o_valid),
	.i_result    (o_result),
	.i_inexact   (o_inexact)
);

// File: tests/fp_add_tb.sv
`timescale 1ns/1ps

module fp_add_tb;
	import fp_add_pkg::*;

	localparam int MAX_VEC     = 64;
	localparam int FIELDS      = 7;    // group mode op a b result inexact
	localparam int N_GROUPS    = 6;
	localparam int DRAIN_LIMIT = 40;   // cycles to empty the pipe

	logic                i_clk;
	logic                i_rst;
	logic                i_valid;
	logic                i_op;
	logic [MODE_W-1:0]   i_mode;
	logic [FP_WIDTH-1:0] i_a;
	logic [FP_WIDTH-1:0] i_b;
	logic                o_valid;
	logic [FP_WIDTH-1:0] o_result;
	logic                o_inexact;

	logic [31:0] vec_mem [0:MAX_VEC*FIELDS-1];
	int          n_vec;
	int          pend_q[$];   // vector indices in flight, oldest first
	int          grp_pass [1:N_GROUPS];
	int          grp_fail [1:N_GROUPS];
	int          total_pass;
	int          total_fail;
	int          other_fail;  // stray outputs, missing data
	bit          timed_out;

	fp_add_top u_dut (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_valid   (i_valid),
		.i_op      (i_op),
		.i_mode    (i_mode),
		.i_a       (i_a),
		.i_b       (i_b),
		.o_valid   (o_valid),
		.o_result  (o_result),
		.o_inexact (o_inexact)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;   // 8 ns period
	end

	function automatic string group_name(input int g);
		case (g)
			1:       return "exact add/sub";
			2:       return "rounding modes";
			3:       return "cancellation";
			4:       return "overflow/underflow";
			5:       return "infinity operands";
			default: return "streaming";
		endcase
	endfunction

	// outputs settle after posedge, read them half a cycle later
	always @(negedge i_clk) begin
		if (!i_rst && o_valid === 1'b1) begin
			check_result();
		end
	end

	task automatic check_result();
		int          idx;
		int          g;
		logic [31:0] want_res;
		logic        want_inx;
		if (pend_q.size() == 0) begin
			$display("unexpected o_valid at %0t with no operation outstanding", $time);
			other_fail++;
			return;
		end
		idx      = pend_q.pop_front();
		g        = vec_mem[idx*FIELDS];
		want_res = vec_mem[idx*FIELDS+5];
		want_inx = vec_mem[idx*FIELDS+6][0];
		if (o_result !== want_res || o_inexact !== want_inx) begin
			$display("[ERROR] %0t: mode %0d op %0d a %h b %h expected %h inexact %0d got %h inexact %0d",
				$time, vec_mem[idx*FIELDS+1], vec_mem[idx*FIELDS+2], vec_mem[idx*FIELDS+3],
				vec_mem[idx*FIELDS+4], want_res, want_inx, o_result, o_inexact);
			grp_fail[g]++;
		end else begin
			grp_pass[g]++;
		end
	endtask

	task automatic apply_vector(input int idx);
		@(negedge i_clk);
		i_valid = 1'b1;
		i_mode  = vec_mem[idx*FIELDS+1][MODE_W-1:0];
		i_op    = vec_mem[idx*FIELDS+2][0];
		i_a     = vec_mem[idx*FIELDS+3];
		i_b     = vec_mem[idx*FIELDS+4];
		pend_q.push_back(idx);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge i_clk);
			i_valid = 1'b0;
		end
	endtask

	// bounded wait until every result of the group came back
	task automatic wait_drain(input int g);
		int cycles;
		cycles = 0;
		while (pend_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge i_clk);
			cycles++;
		end
		if (pend_q.size() != 0) begin
			$display("timeout: group %0d still missing %0d results after %0d cycles",
				g, pend_q.size(), cycles);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_group(input int g);
		int pos;
		int gap;
		pos = 0;
		for (int i = 0; i < n_vec; i++) begin
			if (vec_mem[i*FIELDS] == g) begin
				apply_vector(i);
				if (g == N_GROUPS && pos % 2 == 0) begin
					gap = 0;   // force back to back pairs
				end else begin
					gap = $urandom % 3;
				end
				idle_cycles(gap);
				pos++;
			end
		end
		idle_cycles(1);
		wait_drain(g);
		$display("group %0d %s: %0d passed, %0d failed",
			g, group_name(g), grp_pass[g], grp_fail[g]);
	endtask

	initial begin
		void'($urandom(86));
		i_rst      = 1'b1;
		i_valid    = 1'b0;
		i_op       = 1'b0;
		i_mode     = '0;
		i_a        = '0;
		i_b        = '0;
		total_pass = 0;
		total_fail = 0;
		other_fail = 0;
		timed_out  = 1'b0;
		for (int g = 1; g <= N_GROUPS; g++) begin
			grp_pass[g] = 0;
			grp_fail[g] = 0;
		end

		$readmemh("tests/fp_add_input.txt", vec_mem);
		// stop at the first slot without a known group id
		n_vec = 0;
		while (n_vec < MAX_VEC && !$isunknown(vec_mem[n_vec*FIELDS]) &&
			vec_mem[n_vec*FIELDS] >= 1 && vec_mem[n_vec*FIELDS] <= N_GROUPS) begin
			n_vec++;
		end
		if (n_vec == 0) begin
			$display("no vectors could be read from tests/fp_add_input.txt");
			other_fail++;
		end

		repeat (2) @(posedge i_clk);   // 2 reset cycles
		@(negedge i_clk);
		i_rst = 1'b0;

		for (int g = 1; g <= N_GROUPS && !timed_out; g++) begin
			run_group(g);
		end
		idle_cycles(4);   // room for stray outputs to show up

		for (int g = 1; g <= N_GROUPS; g++) begin
			total_pass += grp_pass[g];
			total_fail += grp_fail[g];
		end
		$display("checks passed %0d, failed %0d, other errors %0d",
			total_pass, total_fail, other_fail);
		if (total_fail == 0 && other_fail == 0 && !timed_out) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
